// ==== dcache.f ====
common/dcache_pkg.sv
dcache/dcache_set_array.sv
dcache/dcache_req_stage.sv
dcache/dcache_lookup.sv
dcache/dcache_ctrl.sv
dcache/dcache_resp.sv
dcache/dcache.sv
sim/mem_model.sv
sim/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dcache_tb -f dcache.f -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();
    localparam int num_tests       = 5;
    localparam int num_random_ops  = 40;
    localparam int resp_limit      = 100;
    localparam int watchdog_cycles = 200 * num_tests + 25 * num_random_ops;

    logic        clk;
    logic        rst;
    cpu_req_t    req;
    logic        resp;
    logic [31:0] rdata;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic [31:0] mem_reads;
    logic [31:0] mem_writes;

    logic [31:0] lfsr_state;
    logic [31:0] shadow [addr_t];
    int          errors;
    int          checks;

    dcache DUT (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .resp    (resp),
        .rdata   (rdata),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    mem_model memory (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .read_count  (mem_reads),
        .write_count (mem_writes)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running", watchdog_cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation FAILED");
        $finish;
    end

    // ================================================
    // Reference model and stimulus helpers
    // ================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] pattern_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c3c_c3c3;
    endfunction

    function automatic logic [31:0] shadow_read(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return pattern_word(a);
    endfunction

    function automatic line_t shadow_line(input addr_t a);
        line_t l;
        addr_t base;
        base = {a[31:5], 5'b0};
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = shadow_read(base + addr_t'(w * 4));
        end
        return l;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return addr_t'((tag << (offset_bits + set_bits)) | (set << offset_bits) | (word << 2));
    endfunction

    // ================================================
    // Compare tasks
    // ================================================
    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %064h, expected %064h", name, got, exp);
        end
    endtask

    // ================================================
    // CPU port access
    // ================================================
    task automatic access(input addr_t a, input logic [3:0] rmask, input logic [3:0] wmask,
                          input logic [31:0] wdata, output logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        req <= '{addr: a, rmask: rmask, wmask: wmask, wdata: wdata};
        // Hold the request until an edge where the cache is not stalled
        @(negedge clk);
        while (DUT.stall && waited < resp_limit) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        req <= '0;
        do begin
            @(negedge clk);
            waited++;
        end while (!resp && waited < resp_limit);
        data = rdata;
        if (!resp) begin
            errors++;
            $display("No response from the cache for address %08h", a);
        end
    endtask

    task automatic read_and_check(input addr_t a);
        logic [31:0] data;
        access(a, 4'hf, 4'h0, 32'h0, data);
        check_word($sformatf("rdata @%08h", a), data, shadow_read(a));
    endtask

    task automatic write_word(input addr_t a, input logic [3:0] wmask, input logic [31:0] wdata);
        logic [31:0] unused;
        logic [31:0] merged;
        access(a, 4'h0, wmask, wdata, unused);
        merged = shadow_read(a);
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        shadow[a] = merged;
    endtask

    // ================================================
    // Directed tests
    // ================================================
    task automatic test_read_miss_hit();
        addr_t       a;
        logic [31:0] reads0;
        logic [31:0] writes0;
        $display("Test: read miss then hit");
        a       = make_addr(0, 9, 2);
        reads0  = mem_reads;
        writes0 = mem_writes;
        read_and_check(a);
        check_count("mem read count", mem_reads, reads0 + 32'd1);
        read_and_check(a);
        check_count("mem read count", mem_reads, reads0 + 32'd1);
        check_count("mem write count", mem_writes, writes0);
    endtask

    task automatic test_byte_write();
        addr_t       a;
        logic [31:0] reads0;
        logic [31:0] writes0;
        $display("Test: byte-masked write hit");
        a = make_addr(1, 2, 1);
        read_and_check(a);
        reads0  = mem_reads;
        writes0 = mem_writes;
        write_word(a, 4'b0101, take_bits(32));
        read_and_check(a);
        write_word(a, 4'b1000, take_bits(32));
        read_and_check(a);
        check_count("mem read count", mem_reads, reads0);
        check_count("mem write count", mem_writes, writes0);
    endtask

    task automatic test_dirty_evict();
        addr_t       first;
        logic [31:0] reads0;
        logic [31:0] writes0;
        $display("Test: dirty eviction");
        first   = make_addr(1, 3, 1);
        reads0  = mem_reads;
        writes0 = mem_writes;
        for (int t = 1; t <= 4; t++) begin
            write_word(make_addr(t, 3, t), 4'hf, take_bits(32));
        end
        check_count("mem write count", mem_writes, writes0);
        write_word(make_addr(5, 3, 5), 4'hf, take_bits(32));
        check_count("mem read count", mem_reads, reads0 + 32'd5);
        check_count("mem write count", mem_writes, writes0 + 32'd1);
        // In a fresh set the tree fills ways 0, 2, 1, 3 and then points at way 0 again
        check_line("evicted line", memory.lines[first[12:5]], shadow_line(first));
        reads0 = mem_reads;
        read_and_check(first);
        check_count("mem read count", mem_reads, reads0 + 32'd1);
    endtask

    task automatic test_plru();
        logic [31:0] reads0;
        $display("Test: PLRU replacement");
        for (int t = 8; t <= 11; t++) begin
            read_and_check(make_addr(t, 5, 0));
        end
        for (int t = 8; t <= 10; t++) begin
            read_and_check(make_addr(t, 5, 0));
        end
        reads0 = mem_reads;
        read_and_check(make_addr(12, 5, 0));
        check_count("mem read count", mem_reads, reads0 + 32'd1);
        for (int t = 8; t <= 10; t++) begin
            read_and_check(make_addr(t, 5, 0));
        end
        check_count("mem read count", mem_reads, reads0 + 32'd1);
        read_and_check(make_addr(11, 5, 0));
        check_count("mem read count", mem_reads, reads0 + 32'd2);
    endtask

    task automatic test_random_traffic();
        addr_t       a;
        int          set;
        logic [31:0] mask;
        $display("Test: random mixed traffic");
        for (int i = 0; i < num_random_ops; i++) begin
            set = (take_bits(1) == 32'd1) ? 8 : 7;
            a   = make_addr(int'(take_bits(3)), set, int'(take_bits(3)));
            if (take_bits(1) == 32'd1) begin
                mask = take_bits(4);
                if (mask[3:0] == 4'h0) begin
                    mask = 32'hf;
                end
                write_word(a, mask[3:0], take_bits(32));
            end else begin
                read_and_check(a);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        req        = '0;
        lfsr_state = 32'hdfee;
        errors     = 0;
        checks     = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_read_miss_hit();
        test_byte_write();
        test_dirty_evict();
        test_plru();
        test_random_traffic();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    mem_req,
    output mem_rsp_t    mem_rsp,
    output logic [31:0] read_count,
    output logic [31:0] write_count
);
    localparam int num_lines = 256;
    localparam int latency   = 3;

    line_t      lines [num_lines];
    logic [1:0] wait_cnt;
    logic [7:0] index;

    assign index = mem_req.addr[12:5];

    // Every word holds a value derived from its own byte address
    function automatic line_t pattern_line(input int idx);
        line_t l;
        addr_t a;
        for (int w = 0; w < 8; w++) begin
            a = addr_t'((idx << 5) | (w << 2));
            l[w*32 +: 32] = a ^ {a[15:0], a[31:16]} ^ 32'h3c3c_c3c3;
        end
        return l;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_lines; i++) begin
                lines[i] <= pattern_line(i);
            end
            mem_rsp     <= '0;
            wait_cnt    <= '0;
            read_count  <= '0;
            write_count <= '0;
        end else begin
            mem_rsp.rvalid <= 1'b0;
            mem_rsp.ready  <= 1'b0;
            // A request that was just answered is still high for one cycle
            if ((mem_req.read || mem_req.write) && !mem_rsp.rvalid && !mem_rsp.ready) begin
                if (wait_cnt == 2'(latency - 1)) begin
                    wait_cnt <= '0;
                    if (mem_req.write) begin
                        lines[index]  <= mem_req.wdata;
                        mem_rsp.ready <= 1'b1;
                        write_count   <= write_count + 32'd1;
                    end else begin
                        mem_rsp.rdata  <= lines[index];
                        mem_rsp.rvalid <= 1'b1;
                        read_count     <= read_count + 32'd1;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 2'd1;
                end
            end
        end
    end

endmodule

// ==== dcache/dcache.sv ====
`timescale 1ns/1ps

module dcache
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cpu_req_t    req,
    output logic        resp,
    output logic [31:0] rdata,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp
);
    stage_t              stage;
    logic [set_bits-1:0] array_set;
    line_t               data_q [num_ways];
    tag_entry_t          tag_q [num_ways];
    logic                valid_q [num_ways];

    logic                hit;
    logic [way_bits-1:0] hit_way;
    logic [way_bits-1:0] replace_way;
    logic                victim_dirty;
    logic                hit_dirty;
    logic                stall;
    logic                allocate_done;
    logic                write_hit;

    logic                array_en;
    logic [num_ways-1:0] data_we;
    logic [num_ways-1:0] tag_we;
    logic [num_ways-1:0] valid_we;
    logic [31:0]         data_lane_mask;
    line_t               data_din;
    tag_entry_t          tag_din;

    dcache_req_stage req_stage (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .stall     (stall),
        .write_hit (write_hit),
        .stage     (stage),
        .array_set (array_set)
    );

    // ================================================
    // Array control
    // ================================================
    // Outputs hold the victim line while memory is busy
    assign array_en = !(mem_req.read || mem_req.write) || allocate_done;

    assign data_lane_mask = write_hit ? (32'(stage.wmask) << stage.offset) : '1;
    assign data_din       = write_hit ? {8{stage.wdata}} : mem_rsp.rdata;
    assign tag_din        = '{dirty: |stage.wmask, tag: stage.tag};

    for (genvar i = 0; i < num_ways; i++) begin : way
        assign data_we[i]  = (allocate_done && replace_way == way_bits'(i))
                           || (write_hit && hit_way == way_bits'(i));
        assign tag_we[i]   = (allocate_done && replace_way == way_bits'(i))
                           || (write_hit && hit_way == way_bits'(i) && !hit_dirty);
        assign valid_we[i] = allocate_done && replace_way == way_bits'(i);

        dcache_set_array #(.entry_t(line_t), .byte_lanes(32)) data_array (
            .clk (clk), .rst (rst), .en (array_en), .we (data_we[i]),
            .lane_mask (data_lane_mask), .set (array_set),
            .din (data_din), .dout (data_q[i])
        );
        dcache_set_array #(.entry_t(tag_entry_t), .byte_lanes(1)) tag_array (
            .clk (clk), .rst (rst), .en (array_en), .we (tag_we[i]),
            .lane_mask (1'b1), .set (array_set),
            .din (tag_din), .dout (tag_q[i])
        );
        dcache_set_array #(.entry_t(logic), .byte_lanes(1)) valid_array (
            .clk (clk), .rst (rst), .en (array_en), .we (valid_we[i]),
            .lane_mask (1'b1), .set (array_set),
            .din (1'b1), .dout (valid_q[i])
        );
    end

    dcache_lookup lookup (
        .clk          (clk),
        .rst          (rst),
        .stage        (stage),
        .array_set    (array_set),
        .tags         (tag_q),
        .valids       (valid_q),
        .resp         (resp),
        .hit          (hit),
        .hit_way      (hit_way),
        .replace_way  (replace_way),
        .victim_dirty (victim_dirty),
        .hit_dirty    (hit_dirty)
    );

    dcache_ctrl ctrl (
        .clk           (clk),
        .rst           (rst),
        .stage         (stage),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .mem_rsp       (mem_rsp),
        .stall         (stall),
        .allocate_done (allocate_done),
        .write_hit     (write_hit),
        .mem_read      (mem_req.read),
        .mem_write     (mem_req.write)
    );

    dcache_resp result (
        .stage       (stage),
        .data_lines  (data_q),
        .tags        (tag_q),
        .hit_way     (hit_way),
        .replace_way (replace_way),
        .mem_write   (mem_req.write),
        .stall       (stall),
        .resp        (resp),
        .rdata       (rdata),
        .mem_addr    (mem_req.addr),
        .mem_wdata   (mem_req.wdata)
    );

endmodule

// ==== dcache/dcache_resp.sv ====
`timescale 1ns/1ps

module dcache_resp
    import dcache_pkg::*;
(
    input  stage_t              stage,
    input  line_t               data_lines [num_ways],
    input  tag_entry_t          tags [num_ways],
    input  logic [way_bits-1:0] hit_way,
    input  logic [way_bits-1:0] replace_way,
    input  logic                mem_write,
    input  logic                stall,
    output logic                resp,
    output logic [31:0]         rdata,
    output addr_t               mem_addr,
    output line_t               mem_wdata
);
    logic [tag_bits-1:0] line_tag;

    assign resp  = (|stage.rmask || |stage.wmask) && !stall;
    assign rdata = data_lines[hit_way][{stage.offset, 3'b000} +: 32];

    // Writeback goes to the victim's own address
    assign line_tag  = mem_write ? tags[replace_way].tag : stage.tag;
    assign mem_addr  = {line_tag, stage.set, {offset_bits{1'b0}}};
    assign mem_wdata = data_lines[replace_way];

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  stage_t   stage,
    input  logic     hit,
    input  logic     victim_dirty,
    input  mem_rsp_t mem_rsp,
    output logic     stall,
    output logic     allocate_done,
    output logic     write_hit,
    output logic     mem_read,
    output logic     mem_write
);
    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_fill,
        st_replay
    } state_t;

    state_t state;
    state_t state_next;
    logic   active;

    assign active = |stage.rmask || |stage.wmask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next    = state;
        stall         = 1'b0;
        allocate_done = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        case (state)
            st_idle: begin
                if (active && !hit) begin
                    stall      = 1'b1;
                    state_next = victim_dirty ? st_writeback : st_fill;
                end else if (|stage.wmask && hit) begin
                    // Re-read the arrays once the written line has settled
                    state_next = st_replay;
                end
            end
            st_writeback: begin
                stall     = 1'b1;
                mem_write = 1'b1;
                if (mem_rsp.ready) begin
                    state_next = st_fill;
                end
            end
            st_fill: begin
                stall    = 1'b1;
                mem_read = 1'b1;
                if (mem_rsp.rvalid) begin
                    allocate_done = 1'b1;
                    state_next    = st_replay;
                end
            end
            st_replay: begin
                stall      = 1'b1;
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    assign write_hit = |stage.wmask && hit && !stall;

    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write));

endmodule

// ==== dcache/dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  stage_t              stage,
    input  logic [set_bits-1:0] array_set,
    input  tag_entry_t          tags [num_ways],
    input  logic                valids [num_ways],
    input  logic                resp,
    output logic                hit,
    output logic [way_bits-1:0] hit_way,
    output logic [way_bits-1:0] replace_way,
    output logic                victim_dirty,
    output logic                hit_dirty
);
    logic [num_ways-1:0]  way_hit;
    logic [plru_bits-1:0] plru_q [num_sets];
    logic [plru_bits-1:0] plru_cur;
    logic [plru_bits-1:0] plru_next;

    // ================================================
    // Hit detection
    // ================================================
    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            way_hit[i] = valids[i] && (tags[i].tag == stage.tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int i = num_ways - 1; i >= 0; i--) begin
            if (way_hit[i]) begin
                hit_way = way_bits'(i);
            end
        end
    end

    assign hit       = |way_hit;
    assign hit_dirty = tags[hit_way].dirty && valids[hit_way];

    // ================================================
    // Tree PLRU
    // ================================================
    // bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    assign replace_way  = plru_cur[0] ? {1'b1, plru_cur[2]} : {1'b0, plru_cur[1]};
    assign victim_dirty = tags[replace_way].dirty && valids[replace_way];

    always_comb begin
        plru_next    = plru_cur;
        plru_next[0] = ~hit_way[1];
        if (hit_way[1]) begin
            plru_next[2] = ~hit_way[0];
        end else begin
            plru_next[1] = ~hit_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_sets; i++) begin
                plru_q[i] <= '0;
            end
            plru_cur <= '0;
        end else begin
            if (resp) begin
                plru_q[stage.set] <= plru_next;
            end
            // Forward an update to the set being read at the same edge
            plru_cur <= (resp && array_set == stage.set) ? plru_next : plru_q[array_set];
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        (|stage.rmask || |stage.wmask) |-> $onehot0(way_hit));

endmodule

// ==== dcache/dcache_req_stage.sv ====
`timescale 1ns/1ps

module dcache_req_stage
    import dcache_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  cpu_req_t            req,
    input  logic                stall,
    input  logic                write_hit,
    output stage_t              stage,
    output logic [set_bits-1:0] array_set
);
    logic [tag_bits-1:0]    req_tag;
    logic [set_bits-1:0]    req_set;
    logic [offset_bits-1:0] req_offset;

    // Address split
    assign req_offset = req.addr[offset_bits-1:0];
    assign req_set    = req.addr[offset_bits +: set_bits];
    assign req_tag    = req.addr[offset_bits + set_bits +: tag_bits];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.rmask <= '0;
            stage.wmask <= '0;
        end else if (!stall) begin
            stage.tag    <= req_tag;
            stage.set    <= req_set;
            stage.offset <= req_offset;
            stage.rmask  <= req.rmask;
            stage.wmask  <= req.wmask;
            stage.wdata  <= req.wdata;
        end
    end

    // Arrays stay on the staged set while it is being written or replayed
    assign array_set = (stall || write_hit) ? stage.set : req_set;

endmodule

// ==== dcache/dcache_set_array.sv ====
`timescale 1ns/1ps

module dcache_set_array
    import dcache_pkg::*;
#(
    parameter type entry_t    = logic,
    parameter int  byte_lanes = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  we,
    input  logic [byte_lanes-1:0] lane_mask,
    input  logic [set_bits-1:0]   set,
    input  entry_t                din,
    output entry_t                dout
);
    localparam int width      = $bits(entry_t);
    localparam int lane_width = width / byte_lanes;

    logic [width-1:0] mem [num_sets];
    logic [width-1:0] bit_mask;

    // Expand lane enables to bit enables
    always_comb begin
        for (int b = 0; b < width; b++) begin
            bit_mask[b] = lane_mask[b / lane_width];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_sets; i++) begin
                mem[i] <= '0;
            end
        end else if (en && we) begin
            mem[set] <= (mem[set] & ~bit_mask) | (din & bit_mask);
        end
    end

    // Read returns the entry as it was before a same-edge write
    always_ff @(posedge clk) begin
        if (en) begin
            dout <= entry_t'(mem[set]);
        end
    end

    a_we_needs_en: assert property (@(posedge clk) disable iff (rst) we |-> en);

endmodule

// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    // ================================================
    // Cache geometry
    // ================================================
    localparam int num_ways    = 4;
    localparam int set_bits    = 4;
    localparam int offset_bits = 5;
    localparam int tag_bits    = 23;
    localparam int way_bits    = 2;
    localparam int plru_bits   = 3;
    localparam int line_bits   = 256;
    localparam int num_sets    = 1 << set_bits;

    typedef logic [31:0] addr_t;
    typedef logic [line_bits-1:0] line_t;

    typedef struct packed {
        logic                dirty;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    // ================================================
    // Port and pipeline structs
    // ================================================
    typedef struct packed {
        addr_t       addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] offset;
        logic [3:0]             rmask;
        logic [3:0]             wmask;
        logic [31:0]            wdata;
    } stage_t;

    // Whole-line transfers toward memory
    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        line_t wdata;
    } mem_req_t;

    typedef struct packed {
        line_t rdata;
        logic  rvalid;
        logic  ready;
    } mem_rsp_t;

endpackage
